// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - source
    files:
      - source/mipsPkg.sv
      - source/registerFile.sv
      - source/alu.sv
      - source/decoder.sv
      - source/controlUnit.sv
      - source/mipsCpuBus.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/avalonMemory.sv
      - verification/mipsCpuBusTb.sv

// File: source/alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    input  mipsPkg::shamtT shamt,
    output mipsPkg::wordT  result,
    output logic           zero
);
    import mipsPkg::*;

    shamtT varShamt;
    logic  lessThan;

    assign varShamt = a[4:0];  // Variable shifts take rs
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = wordT'(lessThan);
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = $signed(b) >>> shamt;
            aluSllv: result = b << varShamt;
            aluSrlv: result = b >> varShamt;
            aluSrav: result = $signed(b) >>> varShamt;
            aluLui:  result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // Branch compare runs through aluSub
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module controlUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                waitrequest,
    input  mipsPkg::wordT       readdata,
    input  mipsPkg::aluOpT      aluOp,
    input  logic                useImmediate,
    input  mipsPkg::wordT       immediate,
    input  mipsPkg::regAddrT    destReg,
    input  logic                regWrite,
    input  logic                isLoad,
    input  logic                isStore,
    input  mipsPkg::branchKindT branchKind,
    input  logic                isLink,
    input  mipsPkg::wordT       aluResult,
    input  logic                zero,
    input  mipsPkg::wordT       rsData,
    input  mipsPkg::wordT       rtData,
    output mipsPkg::wordT       instr,
    output mipsPkg::regAddrT    rsAddr,
    output mipsPkg::regAddrT    rtAddr,
    output logic                wrEnable,
    output mipsPkg::regAddrT    wrAddr,
    output mipsPkg::wordT       wrData,
    output mipsPkg::aluOpT      execAluOp,
    output mipsPkg::wordT       aluA,
    output mipsPkg::wordT       aluB,
    output logic                active,
    output mipsPkg::wordT       address,
    output logic                read,
    output logic                write,
    output mipsPkg::wordT       writedata,
    output logic [3:0]          byteenable
);
    import mipsPkg::*;

    cpuStateT state;
    wordT     pc;
    wordT     pcPlus4;
    wordT     nextPc;
    wordT     target;
    wordT     loadData;
    logic     taken;
    logic     branchTaken;  // Set in execute, delay slot comes next
    logic     slotPending;  // Delay slot in flight, target follows it

    assign pcPlus4 = pc + wordT'(4);
    assign nextPc  = slotPending ? target : pcPlus4;
    assign rsAddr  = instr[25:21];
    assign rtAddr  = instr[20:16];

    always_comb begin
        case (branchKind)
            brBeq:             taken = zero;
            brBne:             taken = !zero;
            brJump, brJumpReg: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= stFetch;
            pc          <= `RESET_VECTOR;
            read        <= 1'b0;
            write       <= 1'b0;
            branchTaken <= 1'b0;
            slotPending <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    if (!read) begin
                        // Only reached after reset or at the halt address
                        if (pc == `HALT_ADDRESS) begin
                            state <= stHalted;
                        end else begin
                            read <= 1'b1;
                        end
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= stDecode;
                    end
                end
                stDecode: state <= stExecute;
                stExecute: begin
                    if (taken) begin
                        branchTaken <= 1'b1;
                    end
                    read  <= isLoad;
                    write <= isStore;
                    state <= stMemory;
                end
                stMemory: begin
                    if (!(read || write) || !waitrequest) begin
                        read  <= 1'b0;
                        write <= 1'b0;
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    pc          <= nextPc;
                    slotPending <= branchTaken;
                    branchTaken <= 1'b0;
                    read        <= (nextPc != `HALT_ADDRESS);  // Fetch strobe ready at once
                    state       <= stFetch;
                end
                default: state <= stHalted;
            endcase
        end
    end

    // Payload latches
    always_ff @(posedge clk) begin
        if (state == stFetch && read && !waitrequest) begin
            instr <= readdata;
        end
        if (state == stDecode) begin
            aluA      <= rsData;
            aluB      <= useImmediate ? immediate : rtData;
            execAluOp <= aluOp;
            writedata <= rtData;
        end
        if (state == stExecute && taken) begin
            case (branchKind)
                brJump:    target <= {pcPlus4[31:28], instr[25:0], 2'b00};
                brJumpReg: target <= aluA;
                default:   target <= pcPlus4 + {immediate[29:0], 2'b00};
            endcase
        end
        if (state == stMemory && read && !waitrequest) begin
            loadData <= readdata;
        end
    end

    assign address    = (state == stMemory) ? aluResult : pc;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;
    assign active     = !(state == stHalted || (state == stFetch && pc == `HALT_ADDRESS));

    assign wrEnable = (state == stWriteback) && regWrite;
    assign wrAddr   = destReg;
    assign wrData   = isLoad ? loadData : isLink ? pc + wordT'(8) : aluResult;

endmodule

`default_nettype wire

// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5

`define RESET_VECTOR    32'hBFC0_0000
`define HALT_ADDRESS    32'h0000_0000  // Fetch from here stops the CPU

`define LINK_REG        5'd31
`define V0_REG          5'd2

`endif

// File: source/decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module decoder (
    input  mipsPkg::wordT       instr,
    output mipsPkg::aluOpT      aluOp,
    output logic                useImmediate,
    output mipsPkg::wordT       immediate,
    output mipsPkg::regAddrT    destReg,
    output logic                regWrite,
    output logic                isLoad,
    output logic                isStore,
    output mipsPkg::branchKindT branchKind,
    output logic                isLink,
    output mipsPkg::shamtT      shamt
);
    import mipsPkg::*;

    opcodeT      opcode;
    funcT        func;
    regAddrT     rt;
    regAddrT     rd;
    logic [15:0] imm16;
    logic        zeroExtend;

    assign opcode = opcodeT'(instr[31:26]);
    assign func   = funcT'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm16  = instr[15:0];
    assign shamt  = instr[10:6];

    // Logical immediates are zero extended
    assign immediate = zeroExtend ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    always_comb begin
        aluOp        = aluAdd;
        useImmediate = 1'b0;
        zeroExtend   = 1'b0;
        destReg      = rt;
        regWrite     = 1'b0;
        isLoad       = 1'b0;
        isStore      = 1'b0;
        branchKind   = brNone;
        isLink       = 1'b0;
        case (opcode)
            opRType: begin
                destReg  = rd;
                regWrite = 1'b1;
                case (func)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnSllv:  aluOp = aluSllv;
                    fnSrlv:  aluOp = aluSrlv;
                    fnSrav:  aluOp = aluSrav;
                    fnJr: begin
                        regWrite   = 1'b0;
                        branchKind = brJumpReg;
                    end
                    default: regWrite = 1'b0;  // Unsupported function
                endcase
            end
            opAddiu: begin
                useImmediate = 1'b1;
                regWrite     = 1'b1;
            end
            opSlti: begin
                aluOp        = aluSlt;
                useImmediate = 1'b1;
                regWrite     = 1'b1;
            end
            opAndi, opOri, opXori: begin
                aluOp        = (opcode == opAndi) ? aluAnd : (opcode == opOri) ? aluOr : aluXor;
                useImmediate = 1'b1;
                zeroExtend   = 1'b1;
                regWrite     = 1'b1;
            end
            opLui: begin
                aluOp        = aluLui;
                useImmediate = 1'b1;
                regWrite     = 1'b1;
            end
            opLw: begin
                useImmediate = 1'b1;
                regWrite     = 1'b1;
                isLoad       = 1'b1;
            end
            opSw: begin
                useImmediate = 1'b1;
                isStore      = 1'b1;
            end
            opBeq, opBne: begin
                aluOp      = aluSub;
                branchKind = (opcode == opBeq) ? brBeq : brBne;
            end
            opJ:   branchKind = brJump;
            opJal: begin
                branchKind = brJump;
                isLink     = 1'b1;
                destReg    = `LINK_REG;
                regWrite   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/mipsCpuBus.sv
`default_nettype none
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic          clk,
    input  logic          rst,
    output logic          active,
    output mipsPkg::wordT registerV0,
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0]    byteenable,
    input  mipsPkg::wordT readdata
);
    import mipsPkg::*;

    wordT       instr;
    aluOpT      aluOp;
    aluOpT      execAluOp;
    logic       useImmediate;
    wordT       immediate;
    regAddrT    destReg;
    logic       regWrite;
    logic       isLoad;
    logic       isStore;
    branchKindT branchKind;
    logic       isLink;
    shamtT      shamt;
    wordT       aluA;
    wordT       aluB;
    wordT       aluResult;
    logic       zero;
    regAddrT    rsAddr;
    regAddrT    rtAddr;
    wordT       rsData;
    wordT       rtData;
    logic       wrEnable;
    regAddrT    wrAddr;
    wordT       wrData;

    controlUnit control0 (
        .clk(clk), .rst(rst), .waitrequest(waitrequest), .readdata(readdata),
        .aluOp(aluOp), .useImmediate(useImmediate), .immediate(immediate),
        .destReg(destReg), .regWrite(regWrite), .isLoad(isLoad), .isStore(isStore),
        .branchKind(branchKind), .isLink(isLink), .aluResult(aluResult), .zero(zero),
        .rsData(rsData), .rtData(rtData), .instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .wrEnable(wrEnable), .wrAddr(wrAddr), .wrData(wrData), .execAluOp(execAluOp),
        .aluA(aluA), .aluB(aluB), .active(active), .address(address), .read(read),
        .write(write), .writedata(writedata), .byteenable(byteenable)
    );

    decoder decoder0 (
        .instr(instr), .aluOp(aluOp), .useImmediate(useImmediate), .immediate(immediate),
        .destReg(destReg), .regWrite(regWrite), .isLoad(isLoad), .isStore(isStore),
        .branchKind(branchKind), .isLink(isLink), .shamt(shamt)
    );

    alu alu0 (
        .aluOp(execAluOp), .a(aluA), .b(aluB), .shamt(shamt), .result(aluResult), .zero(zero)
    );

    registerFile regs0 (
        .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr), .wrEnable(wrEnable),
        .wrAddr(wrAddr), .wrData(wrData), .rsData(rsData), .rtData(rtData),
        .registerV0(registerV0)
    );

endmodule

`default_nettype wire

// File: source/mipsPkg.sv
`default_nettype none

`include "cpu_config.svh"

package mipsPkg;

    typedef logic [`WORD_WIDTH-1:0]     wordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
    typedef logic [4:0]                 shamtT;

    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opAddiu = 6'b001001,
        opSlti  = 6'b001010,
        opAndi  = 6'b001100,
        opOri   = 6'b001101,
        opXori  = 6'b001110,
        opLui   = 6'b001111,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010
    } funcT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll,
        aluSrl, aluSra, aluSllv, aluSrlv, aluSrav, aluLui
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brBeq, brBne, brJump, brJumpReg
    } branchKindT;

    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stMemory    = 3'd3,
        stWriteback = 3'd4,
        stHalted    = 3'd7
    } cpuStateT;

endpackage

`default_nettype wire

// File: source/registerFile.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module registerFile (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::regAddrT rsAddr,
    input  mipsPkg::regAddrT rtAddr,
    input  logic             wrEnable,
    input  mipsPkg::regAddrT wrAddr,
    input  mipsPkg::wordT    wrData,
    output mipsPkg::wordT    rsData,
    output mipsPkg::wordT    rtData,
    output mipsPkg::wordT    registerV0
);
    import mipsPkg::*;

    localparam int numRegs = 1 << `REG_ADDR_WIDTH;

    wordT regs [0:numRegs-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero reads as zero whatever is stored
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    assign registerV0 = regs[`V0_REG];

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/mipsPkg.sv
source/registerFile.sv
source/alu.sv
source/decoder.sv
source/controlUnit.sv
source/mipsCpuBus.sv
verification/avalonMemory.sv
verification/mipsCpuBusTb.sv

// File: verification/avalonMemory.sv
`default_nettype none
`timescale 1ns/1ps

module avalonMemory #(
    parameter logic [31:0] seed = 32'h0000_0001
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          stallEnable,
    input  mipsPkg::wordT address,
    input  logic          read,
    input  logic          write,
    input  mipsPkg::wordT writedata,
    output logic          waitrequest,
    output mipsPkg::wordT readdata,
    input  logic          loadEnable,
    input  mipsPkg::wordT loadAddress,
    input  mipsPkg::wordT loadData,
    output int            writeCount,
    output mipsPkg::wordT lastWriteAddress,
    output mipsPkg::wordT lastWriteData
);
    import mipsPkg::*;

    localparam int depth = 1024;  // 4 KiB, upper address bits ignored

    wordT        mem [0:depth-1];
    logic [31:0] rng = seed;
    logic        stall = 1'b0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign waitrequest = stallEnable && stall;
    assign readdata    = (read === 1'b1) ? mem[address[11:2]] : '0;  // Zero read latency

    always @(posedge clk) begin
        rng   <= xorshift(rng);
        stall <= (rng[2:0] < 3'd3);  // Roughly three cycles in eight
        if (loadEnable) begin
            mem[loadAddress[11:2]] <= loadData;
        end
        if (rst) begin
            writeCount <= 0;
        end else if (write && !waitrequest) begin
            mem[address[11:2]] <= writedata;
            writeCount       <= writeCount + 1;
            lastWriteAddress <= address;
            lastWriteData    <= writedata;
        end
    end

endmodule

`default_nettype wire

// File: verification/mipsCpuBusTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module mipsCpuBusTb;
    import mipsPkg::*;

    localparam int          clkPeriod  = 8;
    localparam int          numRows    = 6;
    localparam int          numPasses  = 2;  // Without and with random waitrequest
    localparam int          progWords  = 12;
    localparam int          rowCycles  = 400;
    localparam int          haltCycles = 20;
    localparam logic [31:0] seed       = 32'h268c_2f61;
    localparam wordT        dataBase   = 32'h0000_0800;
    localparam wordT        nopWord    = 32'h0000_0000;
    localparam wordT        jrZero     = 32'h0000_0008;  // JR $0 ends every program

    logic       clk;
    logic       rst;
    logic       stallEnable;
    logic       loadEnable;
    wordT       loadAddress;
    wordT       loadData;
    logic       active;
    wordT       registerV0;
    wordT       address;
    logic       write;
    logic       read;
    logic       waitrequest;
    wordT       writedata;
    logic [3:0] byteenable;
    wordT       readdata;
    int         writeCount;
    wordT       lastWriteAddress;
    wordT       lastWriteData;

    logic [0:progWords-1][31:0] progTable [numRows];
    wordT expectV0    [numRows];
    logic expectStore [numRows];
    wordT storeAddr   [numRows];
    wordT storeData   [numRows];

    int         errors;
    int         checks;
    int         passIdx;
    int         rowIdx;
    logic [3:0] wantLanes;

    mipsCpuBus dut0 (
        .clk(clk), .rst(rst), .active(active), .registerV0(registerV0), .address(address),
        .write(write), .read(read), .waitrequest(waitrequest), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata)
    );

    avalonMemory #(.seed(seed)) mem0 (
        .clk(clk), .rst(rst), .stallEnable(stallEnable), .address(address), .read(read),
        .write(write), .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata),
        .loadEnable(loadEnable), .loadAddress(loadAddress), .loadData(loadData),
        .writeCount(writeCount), .lastWriteAddress(lastWriteAddress),
        .lastWriteData(lastWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic reportCounts();
        $display("Checks run: %0d, errors: %0d", checks, errors);
    endtask

    task automatic checkValue(input string name, input wordT actual, input wordT expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error: %s = %h, expected %h (pass %0d, row %0d)",
                     name, actual, expected, passIdx, rowIdx);
        end
    endtask

    task automatic checkCondition(input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("Check failed: %s (pass %0d, row %0d)", what, passIdx, rowIdx);
        end
    endtask

    task automatic buildTable();
        // LUI, ORI, then ANDI and XORI with zero-extended immediates, ADDIU -1
        progTable[0] = {32'h3C021234, 32'h34428765, 32'h3042F0F0, 32'h3842FFFF, 32'h2442FFFF,
                        jrZero, nopWord, nopWord, nopWord, nopWord, nopWord, nopWord};
        expectV0[0]  = 32'h0000_7F9E;
        // 100 - (-7), plus SLT result, plus SLTI result shifted left by 4
        progTable[1] = {32'h24080064, 32'h2409FFF9, 32'h01091023, 32'h0128502A, 32'h290BFFFF,
                        32'h004A1021, 32'h292CFFFA, 32'h000C6100, 32'h004C1021, 32'h004B1021,
                        jrZero, nopWord};
        expectV0[1]  = 32'h0000_007C;
        // Shifts of t0 = 0x800000F0 where variable amounts come from its low bits
        // SRA by 20 leaves sign fill that the SLLV by 16 keeps
        progTable[2] = {32'h3C088000, 32'h350800F0, 32'h00084D03, 32'h00085202, 32'h01086006,
                        32'h01086807, 32'h01097004, 32'h014C1026, 32'h004D1026, 32'h004E1026,
                        jrZero, nopWord};
        expectV0[2]  = 32'h077F_0000;
        // SW 0xCAFEF00D to 0x804 then LW it into v0
        progTable[3] = {32'h24080800, 32'h3C09CAFE, 32'h3529F00D, 32'hAD090004, 32'h8D020004,
                        jrZero, nopWord, nopWord, nopWord, nopWord, nopWord, nopWord};
        expectV0[3]  = 32'hCAFE_F00D;
        // Taken BEQ and BNE skip 0x40 and 0x80 while the untaken BEQ falls through
        progTable[4] = {32'h24020001, 32'h10000002, 32'h24420002, 32'h24420040, 32'h14400002,
                        32'h24420004, 32'h24420080, 32'h10400002, 32'h24420008, 32'h24420010,
                        jrZero, nopWord};
        expectV0[4]  = 32'h0000_001F;
        // JAL to word 5, copy $31 in the slot, JR $31 back to word 2
        progTable[5] = {32'h0FF00005, 32'h03E01021, 32'h24420100, jrZero, nopWord,
                        32'h24420020, 32'h03E00008, 32'h24420003, 32'h24420400,
                        nopWord, nopWord, nopWord};
        expectV0[5]  = 32'hBFC0_012B;  // BFC00008 + 0x20 + 3 + 0x100
        for (int r = 0; r < numRows; r++) begin
            expectStore[r] = (r == 3);
            storeAddr[r]   = dataBase + 32'h4;
            storeData[r]   = 32'hCAFE_F00D;
        end
    endtask

    task automatic loadRow(input int r);
        for (int i = 0; i < progWords; i++) begin
            @(posedge clk);
            loadEnable  <= 1'b1;
            loadAddress <= `RESET_VECTOR + 4 * i;
            loadData    <= progTable[r][i];
        end
        @(posedge clk);
        loadAddress <= storeAddr[r];
        loadData    <= ~storeAddr[r];  // Stale marker that a load must not see
        @(posedge clk);
        loadEnable <= 1'b0;
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic watchHalted();
        int busy;
        busy = 0;
        repeat (haltCycles) begin
            @(negedge clk);
            if (read !== 1'b0 || write !== 1'b0 || active !== 1'b0) begin
                busy++;
            end
        end
        checkCondition(busy == 0, "bus access or active seen after halt");
    endtask

    task automatic runRow(input int r);
        loadRow(r);
        applyReset();
        @(negedge clk);
        checkCondition(read === 1'b0 && write === 1'b0, "bus strobe high right after reset");
        checkCondition(active === 1'b1, "active low right after reset");
        @(negedge clk);
        checkCondition(read === 1'b1, "no fetch in the first cycle after reset");
        checkValue("address", address, `RESET_VECTOR);
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        checkValue("address", address, `HALT_ADDRESS);
        checkCondition(read === 1'b0, "fetch issued at the halt address");
        watchHalted();
        checkValue("registerV0", registerV0, expectV0[r]);
        checkValue("writeCount", writeCount, expectStore[r] ? 1 : 0);
        if (expectStore[r]) begin
            checkValue("lastWriteAddress", lastWriteAddress, storeAddr[r]);
            checkValue("lastWriteData", lastWriteData, storeData[r]);
        end
    endtask

    // Byte lanes all on during any access
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            wantLanes = (read || write) ? 4'hF : 4'h0;
            checks++;
            assert (byteenable === wantLanes) else begin
                errors++;
                $display("** Error: byteenable = %h, expected %h", byteenable, wantLanes);
            end
        end
    end

    initial begin
        #(clkPeriod * numPasses * numRows * rowCycles);
        $display("Timeout: the CPU did not halt within %0d cycles",
                 numPasses * numRows * rowCycles);
        reportCounts();
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        stallEnable = 1'b0;
        loadEnable  = 1'b0;
        loadAddress = '0;
        loadData    = '0;
        errors      = 0;
        checks      = 0;
        buildTable();
        for (passIdx = 0; passIdx < numPasses; passIdx++) begin
            @(posedge clk);
            stallEnable <= (passIdx != 0);
            for (rowIdx = 0; rowIdx < numRows; rowIdx++) begin
                runRow(rowIdx);
            end
        end
        reportCounts();
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
